// File: common/fetch_cfg.svh
// fetch config; queue depth must be a power of two (2, 4 or 8), address width stays 32 for RV32I
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

`define FETCH_RESET_PC  32'h0000_0000           // first fetch address out of reset

`define FETCH_NOP       32'h0000_0013           // addi x0, x0, 0

`define FETCH_QDEPTH    4                       // decode queue entries

`define FETCH_QCNT_W    ($clog2(`FETCH_QDEPTH) + 1) // count reaches QDEPTH, so one extra bit

`define FETCH_ADDR_W    32                      // byte address width, word address drops [1:0]

`endif

// File: common/fetch_pkg.sv
// fetch types; widths follow fetch_cfg.svh, opcode values are the RV32I major opcodes
`default_nettype none

`include "fetch_cfg.svh"

package fetch_pkg;

    // byte address of an instruction
    typedef logic [`FETCH_ADDR_W-1:0] pc_t;

    // word address on the imem port, pc[31:2]
    typedef logic [`FETCH_ADDR_W-3:0] waddr_t;

    // one 32-bit instruction, already in instruction bit order
    typedef logic [31:0] instr_t;

    // queue occupancy, 0..QDEPTH
    typedef logic [`FETCH_QCNT_W-1:0] qcnt_t;

    // only the classes predecode cares about
    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011, // beq/bne/blt/bge/bltu/bgeu
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111, // recognised, never predicted
        OP_OTHER  = 7'b0000000  // everything else
    } opcode_e;

endpackage

`default_nettype wire

// File: common/fetch_if.sv
// one predecoded fetch item per cycle; no ready, the queue always has room when valid is high
`timescale 1ns/1ns
`default_nettype none

interface fetch_if;

    logic              valid;      // item present this cycle
    fetch_pkg::pc_t    pc;         // byte address of instr
    fetch_pkg::instr_t instr;      // byte-swapped word
    logic              pred_taken; // static prediction result

    // predecode side
    modport src (
        output valid,
        output pc,
        output instr,
        output pred_taken
    );

    // queue side
    modport dst (
        input valid,
        input pc,
        input instr,
        input pred_taken
    );

endinterface

`default_nettype wire

// File: fetch/fetch_pc.sv
// one imem request in flight at most; first request in the first cycle after reset release, flush wins
`timescale 1ns/1ns
`default_nettype none

`include "fetch_cfg.svh"

module fetch_pc (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             flush,
    input  wire fetch_pkg::pc_t   flush_pc,
    input  wire logic             pred_redirect,
    input  wire fetch_pkg::pc_t   pred_target,
    input  wire fetch_pkg::qcnt_t q_count,
    output logic                  imem_req_valid,
    input  wire logic             imem_req_ready,
    output fetch_pkg::waddr_t     imem_addr,
    input  wire logic             imem_rsp_valid,
    output logic                  rsp_keep,
    output fetch_pkg::pc_t        rsp_pc
);

    fetch_pkg::pc_t   pc_q;        // next address to request
    fetch_pkg::pc_t   req_pc_q;    // address of the request in flight
    logic             outst_q;     // a response is still owed
    logic             epoch_q;     // epoch of the current stream
    logic             req_epoch_q; // epoch the in-flight request was issued in
    logic             req_fire;
    logic             slot_free;
    logic             room;
    logic             redirect;
    logic             epoch_inflight;
    fetch_pkg::qcnt_t pending;

    // reserve a queue slot for the answer still owed, stale or not
    assign pending   = fetch_pkg::qcnt_t'(outst_q);
    assign room      = (q_count + pending) < fetch_pkg::qcnt_t'(`FETCH_QDEPTH);
    assign slot_free = !outst_q || imem_rsp_valid; // back-to-back allowed on the response cycle

    // held low while in reset, up from the first cycle after release
    assign imem_req_valid = rst_n && slot_free && room;
    assign imem_addr      = pc_q[`FETCH_ADDR_W-1:2];
    assign req_fire       = imem_req_valid && imem_req_ready;

    assign redirect = flush || pred_redirect;

    // epoch of whatever is in flight after this edge
    assign epoch_inflight = req_fire ? epoch_q : req_epoch_q;

    // stale answers and answers racing a flush never reach the queue
    assign rsp_keep = imem_rsp_valid && outst_q && (req_epoch_q == epoch_q) && !flush;
    assign rsp_pc   = req_pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q        <= `FETCH_RESET_PC;
            outst_q     <= 1'b0;
            epoch_q     <= 1'b0;
            req_epoch_q <= 1'b0;
        end else begin
            if (flush) begin
                pc_q <= flush_pc;            // back end overrides prediction
            end else if (pred_redirect) begin
                pc_q <= pred_target;
            end else if (req_fire) begin
                pc_q <= pc_q + fetch_pkg::pc_t'(4);
            end

            // new epoch always differs from the in-flight one,
            // so back-to-back flushes cannot revive an old answer
            if (redirect) begin
                epoch_q <= ~epoch_inflight;
            end

            if (req_fire) begin
                outst_q     <= 1'b1;
                req_epoch_q <= epoch_q;      // same-cycle redirect leaves this stale
            end else if (imem_rsp_valid) begin
                outst_q <= 1'b0;
            end
        end
    end

    // pc of the request in flight, payload only
    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_pc_q <= pc_q;
        end
    end

endmodule

`default_nettype wire

// File: fetch/predecode.sv
// combinational only; static rule is backward branch and jal taken, jalr and the rest fall through
`timescale 1ns/1ns
`default_nettype none

module predecode (
    input  wire logic              rsp_keep,
    input  wire fetch_pkg::pc_t    rsp_pc,
    input  wire fetch_pkg::instr_t imem_rsp_data,
    fetch_if.src                   item,
    output logic                   pred_redirect,
    output fetch_pkg::pc_t         pred_target
);

    fetch_pkg::instr_t   word;   // instruction bit order
    fetch_pkg::opcode_e  opc;
    fetch_pkg::pc_t      imm_b;
    fetch_pkg::pc_t      imm_j;
    fetch_pkg::pc_t      offset;
    logic                taken;

    // memory hands back little-endian bytes
    assign word = {imem_rsp_data[7:0],
                   imem_rsp_data[15:8],
                   imem_rsp_data[23:16],
                   imem_rsp_data[31:24]};

    always_comb begin
        case (word[6:0])
            fetch_pkg::OP_BRANCH: opc = fetch_pkg::OP_BRANCH;
            fetch_pkg::OP_JAL:    opc = fetch_pkg::OP_JAL;
            fetch_pkg::OP_JALR:   opc = fetch_pkg::OP_JALR;   // target in a register
            default:              opc = fetch_pkg::OP_OTHER;
        endcase
    end

    // B-type offset, sign in bit 31
    assign imm_b = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};

    // J-type offset
    assign imm_j = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};

    always_comb begin
        taken  = 1'b0;
        offset = imm_b;
        case (opc)
            fetch_pkg::OP_BRANCH: begin
                taken  = word[31];   // negative offset means loop back
                offset = imm_b;
            end
            fetch_pkg::OP_JAL: begin
                taken  = 1'b1;
                offset = imm_j;
            end
            fetch_pkg::OP_JALR: begin
                taken  = 1'b0;       // no predictor for indirect jumps
            end
            default: begin
                taken  = 1'b0;
            end
        endcase
    end

    assign pred_target   = rsp_pc + offset;
    assign pred_redirect = rsp_keep && taken;

    // item to the queue
    assign item.valid      = rsp_keep;
    assign item.pc         = rsp_pc;
    assign item.instr      = word;
    assign item.pred_taken = taken;

endmodule

`default_nettype wire

// File: fetch/fetch_queue.sv
// power-of-two depth; writer must not push when full, fetch_pc guarantees that through count
`timescale 1ns/1ns
`default_nettype none

`include "fetch_cfg.svh"

module fetch_queue (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          flush,
    fetch_if.dst               item,
    output fetch_pkg::qcnt_t   count,
    output logic               dec_valid,
    input  wire logic          dec_ready,
    output fetch_pkg::pc_t     dec_pc,
    output fetch_pkg::instr_t  dec_instr,
    output logic               dec_pred_taken
);

    localparam int DEPTH = `FETCH_QDEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    fetch_pkg::pc_t    pc_mem    [DEPTH];
    fetch_pkg::instr_t instr_mem [DEPTH];
    logic              taken_mem [DEPTH];

    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    fetch_pkg::qcnt_t  count_q;
    logic              push;
    logic              pop;

    assign push = item.valid && !flush;   // flush drops a same-cycle write
    assign pop  = dec_valid && dec_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush) begin
            wr_ptr_q <= '0;               // empty next cycle
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + PTR_W'(1);  // wraps at DEPTH
            if (pop)  rd_ptr_q <= rd_ptr_q + PTR_W'(1);
            count_q <= count_q + fetch_pkg::qcnt_t'(push) - fetch_pkg::qcnt_t'(pop);
        end
    end

    // instr slots start out as nops
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                instr_mem[i] <= `FETCH_NOP;
            end
        end else if (push) begin
            instr_mem[wr_ptr_q] <= item.instr;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr_q]    <= item.pc;
            taken_mem[wr_ptr_q] <= item.pred_taken;
        end
    end

    // head drives decode straight, stable while stalled
    assign dec_valid      = (count_q != '0);
    assign dec_pc         = pc_mem[rd_ptr_q];
    assign dec_instr      = instr_mem[rd_ptr_q];
    assign dec_pred_taken = taken_mem[rd_ptr_q];
    assign count          = count_q;

endmodule

`default_nettype wire

// File: source/fetch_top.sv
// imem must answer in order with latency of at least one cycle; flush beats prediction
`timescale 1ns/1ns
`default_nettype none

module fetch_top (
    input  wire logic              clk,
    input  wire logic              rst_n,
    // back-end redirect
    input  wire logic              flush,
    input  wire fetch_pkg::pc_t    flush_pc,
    // imem request
    output logic                   imem_req_valid,
    input  wire logic              imem_req_ready,
    output fetch_pkg::waddr_t      imem_addr,
    // imem response, little-endian bytes
    input  wire logic              imem_rsp_valid,
    input  wire fetch_pkg::instr_t imem_rsp_data,
    // decode
    output logic                   dec_valid,
    input  wire logic              dec_ready,
    output fetch_pkg::pc_t         dec_pc,
    output fetch_pkg::instr_t      dec_instr,
    output logic                   dec_pred_taken
);

    logic              rsp_keep;
    fetch_pkg::pc_t    rsp_pc;
    logic              pred_redirect;
    fetch_pkg::pc_t    pred_target;
    fetch_pkg::qcnt_t  q_count;

    fetch_if fq_item ();   // predecode -> queue

    fetch_pc u_fetch_pc (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .flush_pc       (flush_pc),
        .pred_redirect  (pred_redirect),
        .pred_target    (pred_target),
        .q_count        (q_count),
        .imem_req_valid (imem_req_valid),
        .imem_req_ready (imem_req_ready),
        .imem_addr      (imem_addr),
        .imem_rsp_valid (imem_rsp_valid),
        .rsp_keep       (rsp_keep),
        .rsp_pc         (rsp_pc)
    );

    predecode u_predecode (
        .rsp_keep       (rsp_keep),
        .rsp_pc         (rsp_pc),
        .imem_rsp_data  (imem_rsp_data),
        .item           (fq_item.src),
        .pred_redirect  (pred_redirect),
        .pred_target    (pred_target)
    );

    fetch_queue u_fetch_queue (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .item           (fq_item.dst),
        .count          (q_count),
        .dec_valid      (dec_valid),
        .dec_ready      (dec_ready),
        .dec_pc         (dec_pc),
        .dec_instr      (dec_instr),
        .dec_pred_taken (dec_pred_taken)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
// 20 ns clock from time 0; rst_n low over the first two rising edges, released 2 ns after the second
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #2 rst_n = 1'b1;            // same skew as the other inputs
    end

    always #10 clk = ~clk;          // half period

endmodule

`default_nettype wire

// File: testbench/tb_fetch.sv
// imem model holds 256 words and answers in order after 1 to 3 cycles; programs must stay inside
`timescale 1ns/1ns
`default_nettype none

`include "fetch_cfg.svh"

module tb_fetch;

    localparam int N_RESET = 1;
    localparam int N_SEQ   = 16;
    localparam int N_PRED  = 12;    // two turns of the branch loop
    localparam int N_FLUSH = 8;
    localparam int N_HOLD  = 10;    // stall cycles so the queue is full at the flush
    localparam int N_RAND  = 150;
    localparam int TEST_CYCLES = N_RESET + N_SEQ + N_PRED + N_FLUSH + N_HOLD + N_RAND;

    logic              clk, rst_n, flush, dec_ready, dec_valid, dec_pred_taken;
    logic              imem_req_valid, imem_req_ready, imem_rsp_valid;
    fetch_pkg::pc_t    flush_pc, dec_pc, ref_pc, flush_tgt, hold_pc;
    fetch_pkg::instr_t imem_rsp_data, dec_instr, hold_instr;
    fetch_pkg::waddr_t imem_addr, acc_addr, busy_addr;
    fetch_pkg::instr_t mem_le [256];  // little-endian words, as the memory holds them
    logic              accepted, busy, flush_req, hold_q, hold_taken;
    logic [31:0]       rnd;
    integer            seed = 32'haf62;
    int                errors, checks, n_acc, wait_cnt;
    int                ready_mode;    // 0 always ready, 1 random, 2 held low

    tb_clock clk_gen (.clk(clk), .rst_n(rst_n));

    fetch_top dut0 (
        .clk(clk), .rst_n(rst_n), .flush(flush), .flush_pc(flush_pc),
        .imem_req_valid(imem_req_valid), .imem_req_ready(imem_req_ready),
        .imem_addr(imem_addr), .imem_rsp_valid(imem_rsp_valid),
        .imem_rsp_data(imem_rsp_data), .dec_valid(dec_valid), .dec_ready(dec_ready),
        .dec_pc(dec_pc), .dec_instr(dec_instr), .dec_pred_taken(dec_pred_taken)
    );

    function automatic fetch_pkg::instr_t byte_swap(input fetch_pkg::instr_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic fetch_pkg::instr_t enc_addi(input logic [11:0] imm);
        return {imm, 5'd0, 3'b000, 5'd1, 7'b0010011};          // addi x1, x0, imm
    endfunction

    function automatic fetch_pkg::instr_t enc_beq(input logic [31:0] off);
        logic [12:0] i;
        i = off[12:0];
        return {i[12], i[10:5], 5'd0, 5'd0, 3'b000, i[4:1], i[11], 7'b1100011};
    endfunction

    function automatic fetch_pkg::instr_t enc_jal(input logic [31:0] off);
        logic [20:0] i;
        i = off[20:0];
        return {i[20], i[10:1], i[11], i[19:12], 5'd0, 7'b1101111};
    endfunction

    // instruction-order word at a byte address
    function automatic fetch_pkg::instr_t word_at(input fetch_pkg::pc_t pc);
        return byte_swap(mem_le[pc[9:2]]);
    endfunction

    // static rule: backward conditional branch or jal
    function automatic logic expect_taken(input fetch_pkg::instr_t w);
        return (w[6:0] == 7'b1100011 && w[31]) || (w[6:0] == 7'b1101111);
    endfunction

    function automatic fetch_pkg::pc_t expect_next(input fetch_pkg::pc_t pc,
                                                   input fetch_pkg::instr_t w);
        fetch_pkg::pc_t off;
        off = 32'd4;
        if (w[6:0] == 7'b1100011 && w[31]) begin
            off = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end else if (w[6:0] == 7'b1101111) begin
            off = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        return pc + off;
    endfunction

    task automatic put_word(input fetch_pkg::pc_t a, input fetch_pkg::instr_t w);
        mem_le[a[9:2]] = byte_swap(w);
    endtask

    task automatic load_program();
        for (int i = 0; i < 256; i++) begin
            mem_le[i] = byte_swap(enc_addi(12'(i)));      // imm tracks the word index
        end
        put_word(32'h104, enc_beq(8));       // forward, falls through
        put_word(32'h10c, enc_jal(32'h14));  // to 0x120
        put_word(32'h124, enc_beq(-36));     // back to 0x100
        put_word(32'h208, enc_beq(12));
        put_word(32'h210, enc_jal(32'h30));  // to 0x240
        put_word(32'h248, enc_beq(-72));     // back to 0x200
    endtask

    task automatic check(input logic ok, input string msg);
        checks = checks + 1;
        assert (ok) else begin
            $display("[FAIL] %0t ns: %s", $time, msg);
            errors = errors + 1;
        end
    endtask

    task automatic run_items(input int n);
        int target;
        target = n_acc + n;
        while (n_acc < target) @(posedge clk);
    endtask

    task automatic flush_to(input fetch_pkg::pc_t target);
        flush_tgt = target;
        flush_req = 1'b1;
        @(posedge clk);
        flush_req = 1'b0;               // one-cycle pulse
    endtask

    task automatic end_test(input string name, inout int mark);
        $display("test %-14s done, items %0d, errors %0d", name, n_acc, errors - mark);
        mark = errors;
    endtask

    // memory answers, ready signals and flush, 2 ns after each rising edge
    initial begin
        flush          = 1'b0;
        flush_pc       = '0;
        imem_req_ready = 1'b0;
        imem_rsp_valid = 1'b0;
        imem_rsp_data  = '0;
        dec_ready      = 1'b0;
        busy           = 1'b0;
        wait_cnt       = 0;
        forever begin
            @(posedge clk);
            #2;
            if (imem_rsp_valid) begin
                imem_rsp_valid = 1'b0;    // answer lasts one cycle
                busy           = 1'b0;
            end
            if (accepted) begin
                busy      = 1'b1;
                busy_addr = acc_addr;
                rnd       = $random(seed);
                wait_cnt  = int'(rnd % 32'd3);
            end
            if (busy) begin
                if (wait_cnt == 0) begin
                    imem_rsp_valid = 1'b1;
                    imem_rsp_data  = mem_le[busy_addr[7:0]];
                end else begin
                    wait_cnt = wait_cnt - 1;
                end
            end
            rnd            = $random(seed);
            imem_req_ready = (rnd[1:0] != 2'b00);      // stalls about a quarter of cycles
            dec_ready      = (ready_mode == 0) || (ready_mode == 1 && rnd[2]);
            flush          = flush_req;
            if (flush_req) begin
                flush_pc  = flush_tgt;
                dec_ready = 1'b0;         // no pop in the flush cycle
            end
        end
    end

    // reference walk and checks at the falling edge, where everything is settled
    initial begin
        errors   = 0;
        checks   = 0;
        n_acc    = 0;
        accepted = 1'b0;
        hold_q   = 1'b0;
        ref_pc   = `FETCH_RESET_PC;
        forever begin
            @(negedge clk);
            accepted = 1'b0;
            if (!rst_n) begin
                check(!imem_req_valid && !dec_valid, "request or decode valid during reset");
            end else begin
                accepted = imem_req_valid && imem_req_ready;    // taken at the coming edge
                acc_addr = imem_addr;
                if (accepted) begin
                    check(!busy || imem_rsp_valid, "request issued while one is outstanding");
                    check(imem_addr[29:8] == '0, "request outside the test memory");
                end
                if (hold_q) begin
                    check(dec_valid && dec_pc == hold_pc && dec_instr == hold_instr
                          && dec_pred_taken == hold_taken, "decode payload moved under stall");
                end
                if (flush) begin
                    ref_pc = flush_pc;      // stream restarts here
                end else if (dec_valid && dec_ready) begin
                    check(dec_pc == ref_pc, $sformatf("pc %h, expected %h", dec_pc, ref_pc));
                    check(dec_instr == word_at(ref_pc),
                          $sformatf("instr %h at %h, expected %h", dec_instr, ref_pc,
                                    word_at(ref_pc)));
                    check(dec_pred_taken == expect_taken(word_at(ref_pc)),
                          $sformatf("pred_taken %b at %h", dec_pred_taken, ref_pc));
                    ref_pc = expect_next(ref_pc, word_at(ref_pc));
                    n_acc  = n_acc + 1;
                end
                hold_q     = dec_valid && !dec_ready && !flush;
                hold_pc    = dec_pc;
                hold_instr = dec_instr;
                hold_taken = dec_pred_taken;
            end
        end
    end

    initial begin
        int err_mark;
        err_mark   = 0;
        ready_mode = 0;
        flush_req  = 1'b0;
        flush_tgt  = '0;
        load_program();
        wait (rst_n === 1'b1);
        run_items(N_RESET);
        end_test("reset", err_mark);
        run_items(N_SEQ);
        end_test("sequential", err_mark);
        flush_to(32'h100);
        run_items(N_PRED);
        end_test("prediction", err_mark);
        ready_mode = 2;                 // let the queue fill up
        repeat (N_HOLD) @(posedge clk);
        flush_to(32'h200);
        ready_mode = 0;
        run_items(N_FLUSH);
        end_test("flush", err_mark);
        ready_mode = 1;
        run_items(N_RAND);
        end_test("back-pressure", err_mark);
        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog, four cycles per expected item plus slack
    initial begin
        repeat (TEST_CYCLES * 4 + 200) @(posedge clk);
        $display("timeout: decode stream stalled, only %0d items delivered", n_acc);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+common
common/fetch_pkg.sv
common/fetch_if.sv
fetch/fetch_pc.sv
fetch/predecode.sv
fetch/fetch_queue.sv
source/fetch_top.sv
testbench/tb_clock.sv
testbench/tb_fetch.sv

// File: Makefile
# Verilator build and run of the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST)) $(wildcard common/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "No errors" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
